/* hw/commando_pkg.sv */
package commando_pkg;

    // One colour component out of a palette PROM
    typedef logic [3:0] color_t;

    // Char pixel: palette from the attribute, then the 2-bit colour
    typedef logic [5:0] char_pxl_t;

    // Palette PROM address, char layer sits in the top quarter
    typedef logic [7:0] pal_addr_t;

    // Char ROM word address: 10-bit tile code and 3-bit row
    typedef logic [12:0] char_addr_t;

    // One ROM row, eight pixels of 2 bits each
    typedef logic [15:0] char_word_t;

    typedef logic [8:0] hcnt_t;
    typedef logic [8:0] vcnt_t;

    // Line geometry, 256 visible columns = 32 tiles
    localparam int H_TOTAL     = 384;
    localparam int H_VIS_START = 128;
    localparam int V_VIS_START = 16;

    // PROM select values on download address bits 10 to 8
    localparam int PROM_RED   = 0;
    localparam int PROM_GREEN = 1;
    localparam int PROM_BLUE  = 2;

endpackage

/* hw/commando_prom.sv */
`timescale 1ns/1ps

module commando_prom import commando_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  pal_addr_t wr_addr,
    input  color_t    din,
    input  pal_addr_t rd_addr,
    output color_t    dout
);

    color_t mem [256];

    // Blank PROM until the download fills it
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

    // Registered read, one clk of latency
    always_ff @(posedge clk) begin
        dout <= mem[rd_addr];
    end

endmodule

/* hw/commando_video_timer.sv */
`timescale 1ns/1ps

module commando_video_timer import commando_pkg::*; #(
    parameter int V_TOTAL   = 264,
    parameter int V_VISIBLE = 224
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  cen6,
    output hcnt_t h,
    output vcnt_t v,
    output logic  lhbl_pre,
    output logic  lvbl_pre,
    output logic  hs,
    output logic  vs
);

    // Sync windows, both kept inside horizontal blanking
    localparam int HS_START = 32;
    localparam int HS_END   = 64;
    localparam int VS_HEND  = 96;
    // Vertical sync lines a little after the last visible line
    localparam int VS_LINE  = V_VIS_START + V_VISIBLE + 2;
    localparam int VS_LINES = 2;

    logic [1:0] div;
    logic       h_last;
    logic       v_last;
    logic       hs_win;
    logic       vs_win;

    // Master clock divided by four
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div  <= 2'd0;
            cen6 <= 1'b0;
        end else begin
            div  <= div + 2'd1;
            cen6 <= (div == 2'd3);
        end
    end

    assign h_last = (h == hcnt_t'(H_TOTAL - 1));
    assign v_last = (v == vcnt_t'(V_TOTAL - 1));

    // H and V counters, V steps where H wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (cen6) begin
            if (h_last) begin
                h <= '0;
                if (v_last) begin
                    v <= '0;
                end else begin
                    v <= v + vcnt_t'(1);
                end
            end else begin
                h <= h + hcnt_t'(1);
            end
        end
    end

    // Blanking straight from the counts
    assign lhbl_pre = (h >= hcnt_t'(H_VIS_START));
    assign lvbl_pre = (v >= vcnt_t'(V_VIS_START)) &&
                      (v <  vcnt_t'(V_VIS_START + V_VISIBLE));

    assign hs_win = (h >= hcnt_t'(HS_START)) && (h < hcnt_t'(HS_END));

    // VS only pulses during the H blank of its lines
    assign vs_win = (v >= vcnt_t'(VS_LINE)) && (v < vcnt_t'(VS_LINE + VS_LINES)) &&
                    (h >= hcnt_t'(HS_START)) && (h < hcnt_t'(VS_HEND));

    // Syncs are active low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs <= 1'b1;
            vs <= 1'b1;
        end else begin
            hs <= !hs_win;
            vs <= !vs_win;
        end
    end

endmodule

/* hw/commando_char.sv */
`timescale 1ns/1ps

module commando_char import commando_pkg::*; #(
    parameter int V_VISIBLE = 224
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen6,
    input  hcnt_t       h,
    input  vcnt_t       v,
    input  logic        lhbl_pre,
    input  logic        lvbl_pre,
    // CPU port
    input  logic        char_cs,
    input  logic        rnw,
    input  logic [10:0] cpu_ab,
    input  logic [7:0]  cpu_dout,
    output logic [7:0]  char_dout,
    // Graphics ROM
    output char_addr_t  char_rom_addr,
    output logic        char_rom_cs,
    input  char_word_t  char_rom_data,
    input  logic        char_rom_ok,
    // Pixel output
    output char_pxl_t   char_pxl,
    output logic        lhbl_d,
    output logic        lvbl_d
);

    // First tile is requested 16 columns before the visible area
    localparam int FETCH_START = H_VIS_START - 16;
    localparam int FETCH_END   = H_TOTAL - 16;
    // Output delays in pixels, from the shifter and from the blanking inputs
    localparam int PXL_DLY = 24;
    localparam int BLK_DLY = 17;

    logic [7:0]   code_ram [1024];
    logic [7:0]   attr_ram [1024];
    logic [7:0]   code_q;
    logic [7:0]   attr_q;
    hcnt_t        hrel;
    vcnt_t        vrel;
    logic [9:0]   scan_addr;
    logic         tile_start;
    logic         fetch_en;
    logic         issue;
    logic         accept;
    logic         want;
    logic         stale;
    logic         word_ok;
    char_addr_t   job_addr;
    char_word_t   word_buf;
    char_word_t   shift;
    logic [3:0]   pal_next;
    logic [3:0]   pal_cur;
    char_pxl_t    pxl_dl [PXL_DLY];
    logic [BLK_DLY-1:0] lhbl_dl;
    logic [BLK_DLY-1:0] lvbl_dl;

    assign hrel      = h - hcnt_t'(FETCH_START);
    assign vrel      = v - vcnt_t'(V_VIS_START);
    assign scan_addr = {vrel[7:3], hrel[7:3]};

    // Tile RAMs, CPU on one side and the scan on the other
    always_ff @(posedge clk) begin
        if (char_cs && !rnw) begin
            if (cpu_ab[10]) begin
                attr_ram[cpu_ab[9:0]] <= cpu_dout;
            end else begin
                code_ram[cpu_ab[9:0]] <= cpu_dout;
            end
        end
        char_dout <= cpu_ab[10] ? attr_ram[cpu_ab[9:0]] : code_ram[cpu_ab[9:0]];
        code_q    <= code_ram[scan_addr];
        attr_q    <= attr_ram[scan_addr];
    end

    assign tile_start = cen6 && (h[2:0] == 3'd0);
    assign fetch_en   = (h >= hcnt_t'(FETCH_START)) && (h < hcnt_t'(FETCH_END)) &&
                        (vrel < vcnt_t'(V_VISIBLE));

    // Data landing on a tile boundary is already too late
    assign issue  = !char_rom_cs && want && !tile_start;
    assign accept = char_rom_cs && char_rom_ok && !stale && !tile_start;

    // ROM handshake, cs is the busy state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_rom_cs <= 1'b0;
            want        <= 1'b0;
            stale       <= 1'b0;
            word_ok     <= 1'b0;
        end else begin
            if (char_rom_cs && char_rom_ok) begin
                char_rom_cs <= 1'b0;
                stale       <= 1'b0;
            end else if (issue) begin
                char_rom_cs <= 1'b1;
                want        <= 1'b0;
            end
            if (accept) begin
                word_ok <= 1'b1;
            end
            if (tile_start) begin
                word_ok <= 1'b0;
                want    <= fetch_en;
                // Request still out, its tile has gone by
                if (char_rom_cs && !char_rom_ok) begin
                    stale <= 1'b1;
                end
            end
        end
    end

    // Job capture, ROM address and pixel shifter
    always_ff @(posedge clk) begin
        if (issue) begin
            char_rom_addr <= job_addr;
        end
        if (accept) begin
            word_buf <= char_rom_data;
        end
        if (tile_start) begin
            job_addr <= {attr_q[7:6], code_q, vrel[2:0]};
            pal_next <= attr_q[3:0];
            pal_cur  <= pal_next;
            shift    <= word_ok ? word_buf : '0;
        end else if (cen6) begin
            shift <= {shift[13:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (cen6) begin
            pxl_dl[0] <= {pal_cur, shift[15:14]};
            for (int i = 1; i < PXL_DLY; i++) begin
                pxl_dl[i] <= pxl_dl[i-1];
            end
        end
    end

    // Blanking follows the pixel through the same delay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_dl <= '0;
            lvbl_dl <= '0;
        end else if (cen6) begin
            lhbl_dl <= {lhbl_dl[BLK_DLY-2:0], lhbl_pre};
            lvbl_dl <= {lvbl_dl[BLK_DLY-2:0], lvbl_pre};
        end
    end

    assign char_pxl = pxl_dl[PXL_DLY-1];
    assign lhbl_d   = lhbl_dl[BLK_DLY-1];
    assign lvbl_d   = lvbl_dl[BLK_DLY-1];

endmodule

/* hw/commando_colmix.sv */
`timescale 1ns/1ps

module commando_colmix import commando_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  char_pxl_t   char_pxl,
    input  logic        lhbl_d,
    input  logic        lvbl_d,
    // Download port
    input  logic [10:0] prog_addr,
    input  color_t      prog_data,
    input  logic        prog_we,
    // Video out
    output color_t      red,
    output color_t      green,
    output color_t      blue,
    output logic        lhbl,
    output logic        lvbl
);

    logic [2:0] prom_sel;
    pal_addr_t  pal_addr;
    color_t     red_q;
    color_t     green_q;
    color_t     blue_q;
    logic       lhbl_q;
    logic       lvbl_q;

    // One-hot PROM select from download address bits 10 to 8
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            prom_sel[i] = (prog_addr[10:8] == 3'(i));
        end
    end

    // Char palettes live in the top quarter
    assign pal_addr = {2'b11, char_pxl};

    commando_prom u_prom_red (
        .clk     ( clk                          ),
        .we      ( prog_we && prom_sel[PROM_RED] ),
        .wr_addr ( prog_addr[7:0]               ),
        .din     ( prog_data                    ),
        .rd_addr ( pal_addr                     ),
        .dout    ( red_q                        )
    );

    commando_prom u_prom_green (
        .clk     ( clk                            ),
        .we      ( prog_we && prom_sel[PROM_GREEN] ),
        .wr_addr ( prog_addr[7:0]                 ),
        .din     ( prog_data                      ),
        .rd_addr ( pal_addr                       ),
        .dout    ( green_q                        )
    );

    commando_prom u_prom_blue (
        .clk     ( clk                           ),
        .we      ( prog_we && prom_sel[PROM_BLUE] ),
        .wr_addr ( prog_addr[7:0]                ),
        .din     ( prog_data                     ),
        .rd_addr ( pal_addr                      ),
        .dout    ( blue_q                        )
    );

    // Blanking waits one clk for the PROM read, then both get registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_q <= 1'b0;
            lvbl_q <= 1'b0;
            lhbl   <= 1'b0;
            lvbl   <= 1'b0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else begin
            lhbl_q <= lhbl_d;
            lvbl_q <= lvbl_d;
            lhbl   <= lhbl_q;
            lvbl   <= lvbl_q;
            if (lhbl_q && lvbl_q) begin
                red   <= red_q;
                green <= green_q;
                blue  <= blue_q;
            end else begin
                // Black outside the active area
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

/* hw/commando_game.sv */
`timescale 1ns/1ps

module commando_game import commando_pkg::*; #(
    parameter int V_TOTAL   = 264,
    parameter int V_VISIBLE = 224
) (
    input  logic        clk,
    input  logic        rst_n,
    // CPU side
    input  logic        char_cs,
    input  logic        rnw,
    input  logic [10:0] cpu_ab,
    input  logic [7:0]  cpu_dout,
    output logic [7:0]  char_dout,
    // Char ROM
    output char_addr_t  char_rom_addr,
    output logic        char_rom_cs,
    input  char_word_t  char_rom_data,
    input  logic        char_rom_ok,
    // PROM download
    input  logic [10:0] prog_addr,
    input  color_t      prog_data,
    input  logic        prog_we,
    // Video
    output color_t      red,
    output color_t      green,
    output color_t      blue,
    output logic        lhbl,
    output logic        lvbl,
    output logic        hs,
    output logic        vs
);

    logic      cen6;
    hcnt_t     h;
    vcnt_t     v;
    logic      lhbl_pre;
    logic      lvbl_pre;
    char_pxl_t char_pxl;
    logic      lhbl_d;
    logic      lvbl_d;

    commando_video_timer #(
        .V_TOTAL   ( V_TOTAL   ),
        .V_VISIBLE ( V_VISIBLE )
    ) u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen6     ( cen6     ),
        .h        ( h        ),
        .v        ( v        ),
        .lhbl_pre ( lhbl_pre ),
        .lvbl_pre ( lvbl_pre ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

    commando_char #(
        .V_VISIBLE ( V_VISIBLE )
    ) u_char (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cen6          ( cen6          ),
        .h             ( h             ),
        .v             ( v             ),
        .lhbl_pre      ( lhbl_pre      ),
        .lvbl_pre      ( lvbl_pre      ),
        .char_cs       ( char_cs       ),
        .rnw           ( rnw           ),
        .cpu_ab        ( cpu_ab        ),
        .cpu_dout      ( cpu_dout      ),
        .char_dout     ( char_dout     ),
        .char_rom_addr ( char_rom_addr ),
        .char_rom_cs   ( char_rom_cs   ),
        .char_rom_data ( char_rom_data ),
        .char_rom_ok   ( char_rom_ok   ),
        .char_pxl      ( char_pxl      ),
        .lhbl_d        ( lhbl_d        ),
        .lvbl_d        ( lvbl_d        )
    );

    commando_colmix u_colmix (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .char_pxl  ( char_pxl  ),
        .lhbl_d    ( lhbl_d    ),
        .lvbl_d    ( lvbl_d    ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      )
    );

endmodule

/* sim/commando_chk.sv */
`timescale 1ns/1ps

module commando_chk import commando_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input color_t     red,
    input color_t     green,
    input color_t     blue,
    input logic       lhbl,
    input logic       lvbl,
    input logic       hs,
    input logic       vs,
    input logic       char_rom_cs,
    input logic       char_rom_ok,
    input char_addr_t char_rom_addr
);

    // Failed assertions, read back at the end of the run
    int fail_count = 0;

    // Black outside the active area
    a_black_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!lhbl || !lvbl) |-> (red == '0 && green == '0 && blue == '0))
    else begin
        fail_count++;
        $error("colour is not black during blanking");
    end

    // Request held with a stable address until the ROM answers
    a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (char_rom_cs && !char_rom_ok) |=> (char_rom_cs && $stable(char_rom_addr)))
    else begin
        fail_count++;
        $error("char ROM request dropped or changed before ok");
    end

    a_sync_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        lhbl |-> (hs && vs))
    else begin
        fail_count++;
        $error("sync pulse inside the visible line");
    end

endmodule

/* sim/commando_tb.sv */
`timescale 1ns/1ps

module commando_tb import commando_pkg::*;;

    localparam int V_TOTAL      = 40;
    localparam int V_VISIBLE    = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int CLKS_PER_PIX = 4;
    localparam int VIS_PIXELS   = 256;
    localparam int LINE_CLKS    = H_TOTAL * CLKS_PER_PIX;
    localparam int FRAME_CLKS   = V_TOTAL * LINE_CLKS;
    localparam int WAIT_LIMIT   = 2 * FRAME_CLKS;
    localparam int NORMAL_DELAY = 2;
    // More than 8 pixel enables
    localparam int LATE_DELAY   = 40;

    logic        clk;
    logic        rst_n;
    logic        char_cs;
    logic        rnw;
    logic [10:0] cpu_ab;
    logic [7:0]  cpu_dout;
    logic [7:0]  char_dout;
    char_addr_t  char_rom_addr;
    logic        char_rom_cs;
    char_word_t  char_rom_data;
    logic        char_rom_ok;
    logic [10:0] prog_addr;
    color_t      prog_data;
    logic        prog_we;
    color_t      red;
    color_t      green;
    color_t      blue;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;

    integer      seed;
    int          value_errors;
    int          timeout_errors;
    int          assert_errors;
    int          rom_delay;
    color_t      red_tab [256];
    color_t      green_tab [256];
    color_t      blue_tab [256];
    logic [7:0]  code_tab [64];
    logic [7:0]  attr_tab [64];

    commando_game #(
        .V_TOTAL   ( V_TOTAL   ),
        .V_VISIBLE ( V_VISIBLE )
    ) i_commando_game (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .char_cs       ( char_cs       ),
        .rnw           ( rnw           ),
        .cpu_ab        ( cpu_ab        ),
        .cpu_dout      ( cpu_dout      ),
        .char_dout     ( char_dout     ),
        .char_rom_addr ( char_rom_addr ),
        .char_rom_cs   ( char_rom_cs   ),
        .char_rom_data ( char_rom_data ),
        .char_rom_ok   ( char_rom_ok   ),
        .prog_addr     ( prog_addr     ),
        .prog_data     ( prog_data     ),
        .prog_we       ( prog_we       ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .hs            ( hs            ),
        .vs            ( vs            )
    );

    bind commando_game commando_chk u_chk (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .hs            ( hs            ),
        .vs            ( vs            ),
        .char_rom_cs   ( char_rom_cs   ),
        .char_rom_ok   ( char_rom_ok   ),
        .char_rom_addr ( char_rom_addr )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ROM word is the code times 257 with the row folded into the low bits
    function automatic char_word_t rom_word(input logic [9:0] code, input logic [2:0] row);
        return char_word_t'(code * 257) ^ char_word_t'(row);
    endfunction

    // Char ROM model answering with a one-cycle ok after rom_delay clk
    initial begin : rom_model
        int wait_clks;
        wait_clks     = 0;
        char_rom_ok   = 1'b0;
        char_rom_data = '0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (char_rom_ok) begin
                char_rom_ok = 1'b0;
                wait_clks   = 0;
            end else if (char_rom_cs) begin
                wait_clks++;
                if (wait_clks >= rom_delay) begin
                    char_rom_data = rom_word(char_rom_addr[12:3], char_rom_addr[2:0]);
                    char_rom_ok   = 1'b1;
                end
            end else begin
                wait_clks = 0;
            end
        end
    end

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic wait_lhbl(input logic level, output bit ok);
        int n;
        n = 0;
        while (lhbl !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (lhbl === level);
        if (!ok) begin
            timeout_errors++;
            $display("Timeout: lhbl did not go to %b within %0d clk", level, WAIT_LIMIT);
        end
    endtask

    task automatic wait_lvbl(input logic level, output bit ok);
        int n;
        n = 0;
        while (lvbl !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = (lvbl === level);
        if (!ok) begin
            timeout_errors++;
            $display("Timeout: lvbl did not go to %b within %0d clk", level, WAIT_LIMIT);
        end
    endtask

    task automatic cpu_write(input logic [10:0] addr, input logic [7:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        char_cs  = 1'b1;
        rnw      = 1'b0;
        cpu_ab   = addr;
        cpu_dout = data;
        @(posedge clk);
        #DRIVE_DLY;
        char_cs = 1'b0;
        rnw     = 1'b1;
    endtask

    task automatic cpu_read(input logic [10:0] addr, output logic [7:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        char_cs = 1'b1;
        rnw     = 1'b1;
        cpu_ab  = addr;
        @(posedge clk);
        @(negedge clk);
        data = char_dout;
        @(posedge clk);
        #DRIVE_DLY;
        char_cs = 1'b0;
    endtask

    task automatic prom_write(input logic [2:0] sel, input logic [7:0] idx, input color_t data);
        @(posedge clk);
        #DRIVE_DLY;
        prog_addr = {sel, idx};
        prog_data = data;
        prog_we   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        prog_we = 1'b0;
    endtask

    // Random codes and attributes for the two visible tile rows
    task automatic fill_tiles();
        for (int i = 0; i < 64; i++) begin
            code_tab[i] = 8'($random(seed));
            attr_tab[i] = 8'($random(seed));
            cpu_write({1'b0, 10'(i)}, code_tab[i]);
            cpu_write({1'b1, 10'(i)}, attr_tab[i]);
        end
    endtask

    // Palette PROM entry for one visible pixel
    function automatic pal_addr_t expected_index(input int line, input int x, input bit late);
        int         tile;
        logic [9:0] code;
        char_word_t word;
        logic [1:0] col;
        tile = (line / 8) * 32 + x / 8;
        code = {attr_tab[tile][7:6], code_tab[tile]};
        word = rom_word(code, 3'(line % 8));
        col  = late ? 2'b00 : word[15 - 2 * (x % 8) -: 2];
        return {2'b11, attr_tab[tile][3:0], col};
    endfunction

    // Line counts from the first rising lhbl after lvbl rises
    task automatic check_line(input string name, input int line, input bit late);
        bit        ok;
        pal_addr_t idx;
        @(negedge clk);
        wait_lvbl(1'b0, ok);
        if (ok) begin
            wait_lvbl(1'b1, ok);
        end
        for (int l = 0; l <= line && ok; l++) begin
            wait_lhbl(1'b0, ok);
            if (ok) begin
                wait_lhbl(1'b1, ok);
            end
        end
        if (ok) begin
            for (int x = 0; x < VIS_PIXELS; x++) begin
                if (x > 0) begin
                    repeat (CLKS_PER_PIX) @(negedge clk);
                end
                idx = expected_index(line, x, late);
                check_color($sformatf("%s line %0d x %0d red", name, line, x),
                            red_tab[idx], red);
                check_color($sformatf("%s line %0d x %0d green", name, line, x),
                            green_tab[idx], green);
                check_color($sformatf("%s line %0d x %0d blue", name, line, x),
                            blue_tab[idx], blue);
            end
        end
    endtask

    task automatic check_idle_outputs(input string name);
        check_flag({name, " hs"}, 1'b1, hs);
        check_flag({name, " vs"}, 1'b1, vs);
        check_flag({name, " char_rom_cs"}, 1'b0, char_rom_cs);
        check_flag({name, " lhbl"}, 1'b0, lhbl);
        check_flag({name, " lvbl"}, 1'b0, lvbl);
        check_color({name, " red"}, '0, red);
        check_color({name, " green"}, '0, green);
        check_color({name, " blue"}, '0, blue);
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_idle_outputs("test_reset during");
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        // A couple of pixel enables out of reset
        repeat (8) @(negedge clk);
        check_idle_outputs("test_reset after");
    endtask

    task automatic test_cpu_ram();
        logic [9:0] base;
        logic [9:0] addr [32];
        logic [7:0] code_exp [32];
        logic [7:0] attr_exp [32];
        logic [7:0] got;
        base = 10'($random(seed));
        // Stride 33 keeps all 32 addresses apart
        for (int i = 0; i < 32; i++) begin
            addr[i]     = base + 10'(i * 33);
            code_exp[i] = 8'($random(seed));
            attr_exp[i] = 8'($random(seed));
            cpu_write({1'b0, addr[i]}, code_exp[i]);
            cpu_write({1'b1, addr[i]}, attr_exp[i]);
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read({1'b0, addr[i]}, got);
            check_byte("test_cpu_ram code", code_exp[i], got);
            cpu_read({1'b1, addr[i]}, got);
            check_byte("test_cpu_ram attr", attr_exp[i], got);
        end
    endtask

    task automatic test_palette_display();
        for (int i = 0; i < 256; i++) begin
            red_tab[i]   = color_t'($random(seed));
            green_tab[i] = color_t'($random(seed));
            blue_tab[i]  = color_t'($random(seed));
        end
        for (int i = 0; i < 256; i++) begin
            prom_write(3'(PROM_RED), 8'(i), red_tab[i]);
            prom_write(3'(PROM_GREEN), 8'(i), green_tab[i]);
            prom_write(3'(PROM_BLUE), 8'(i), blue_tab[i]);
        end
        // Selects 3 to 7 hit no PROM
        for (int i = 0; i < 10; i++) begin
            prom_write(3'(3 + i % 5), 8'(192 + i * 6), color_t'($random(seed)));
        end
        fill_tiles();
        check_line("test_palette_display", 2, 1'b0);
        check_line("test_palette_display", 13, 1'b0);
    endtask

    task automatic test_geometry();
        bit   ok;
        bit   done;
        bit   vs_low;
        int   frame_clks;
        int   line_clks;
        int   hi_clks;
        int   rises;
        int   vis_lines;
        int   hs_falls;
        logic lhbl_last;
        logic lvbl_last;
        logic hs_last;
        @(negedge clk);
        wait_lvbl(1'b0, ok);
        if (ok) begin
            wait_lvbl(1'b1, ok);
        end
        for (int f = 0; f < 2 && ok; f++) begin
            frame_clks = 0;
            line_clks  = 0;
            hi_clks    = 0;
            rises      = 0;
            vis_lines  = 0;
            hs_falls   = 0;
            vs_low     = 1'b0;
            done       = 1'b0;
            lhbl_last  = lhbl;
            lvbl_last  = lvbl;
            hs_last    = hs;
            while (!done && frame_clks < WAIT_LIMIT) begin
                @(negedge clk);
                frame_clks++;
                line_clks++;
                if (lhbl) begin
                    hi_clks++;
                end
                if (lhbl && !lhbl_last) begin
                    if (rises > 0) begin
                        check_count("test_geometry line clk", LINE_CLKS, line_clks);
                    end
                    rises++;
                    line_clks = 0;
                    if (lvbl) begin
                        vis_lines++;
                    end
                end
                if (!lhbl && lhbl_last) begin
                    check_count("test_geometry lhbl clk", VIS_PIXELS * CLKS_PER_PIX, hi_clks);
                    hi_clks = 0;
                end
                if (!hs && hs_last) begin
                    hs_falls++;
                end
                if (!vs) begin
                    vs_low = 1'b1;
                end
                done      = lvbl && !lvbl_last;
                lhbl_last = lhbl;
                lvbl_last = lvbl;
                hs_last   = hs;
            end
            if (done) begin
                check_count("test_geometry frame clk", FRAME_CLKS, frame_clks);
                check_count("test_geometry lines", V_TOTAL, rises);
                check_count("test_geometry visible lines", V_VISIBLE, vis_lines);
                // One HS pulse per line and some VS pulse per frame
                check_count("test_geometry hs pulses", V_TOTAL, hs_falls);
                check_flag("test_geometry vs pulse", 1'b1, vs_low);
            end else begin
                timeout_errors++;
                $display("Timeout: no second rising lvbl within %0d clk", WAIT_LIMIT);
                ok = 1'b0;
            end
        end
    endtask

    task automatic test_rom_late();
        rom_delay = LATE_DELAY;
        check_line("test_rom_late", 4, 1'b1);
        check_line("test_rom_late", 11, 1'b1);
        // Pixels return once the ROM is fast again
        rom_delay = NORMAL_DELAY;
        check_line("test_rom_late recovery", 6, 1'b0);
    endtask

    initial begin
        seed           = 32'h8087_e538;
        value_errors   = 0;
        timeout_errors = 0;
        rom_delay      = NORMAL_DELAY;
        rst_n          = 1'b0;
        char_cs        = 1'b0;
        rnw            = 1'b1;
        cpu_ab         = '0;
        cpu_dout       = '0;
        prog_addr      = '0;
        prog_data      = '0;
        prog_we        = 1'b0;
        // Tiles and palettes get loaded before the first visible line
        test_reset();
        test_cpu_ram();
        test_palette_display();
        test_geometry();
        test_rom_late();
        assert_errors = i_commando_game.u_chk.fail_count;
        $display("Errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeout_errors, assert_errors);
        if (value_errors == 0 && timeout_errors == 0 && assert_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/commando_pkg.sv
hw/commando_prom.sv
hw/commando_video_timer.sv
hw/commando_char.sv
hw/commando_colmix.sv
hw/commando_game.sv
sim/commando_chk.sv
sim/commando_tb.sv

/* Bender.yml */
package:
  name: commando_video

sources:
  - files:
      - hw/commando_pkg.sv
      - hw/commando_prom.sv
      - hw/commando_video_timer.sv
      - hw/commando_char.sv
      - hw/commando_colmix.sv
      - hw/commando_game.sv
  - target: simulation
    files:
      - sim/commando_chk.sv
      - sim/commando_tb.sv
